// ==== hw/dcache_pkg.sv ====
/*
 * shared data cache definitions
 * data, strobe, offset and address widths
 * controller state encoding and byte merge helper
 */
`default_nettype none

package dcache_pkg;

  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned OFF_W  = 3;  // byte offset in a line
  localparam int unsigned ADDR_W = 32;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WB_ADDR,
    S_WB_RESP,
    S_FILL_ADDR,
    S_FILL_DATA,
    S_RESP
  } ctrl_state_e;

  // replace strobed bytes of old_data with new_data
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_data,
    input logic [DATA_W-1:0] new_data,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_data;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== hw/cache_way_if.sv ====
/*
 * lookup, result and update bundle for one cache way
 * modports for the controller and the way store
 */
`timescale 1ns/1ns
`default_nettype none

interface cache_way_if #(
  parameter int IDX_W = 6
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic              upd_en;
  logic [DATA_W-1:0] upd_data;
  logic [STRB_W-1:0] upd_strb;
  logic              upd_dirty;
  logic [TAG_W-1:0]  upd_tag;
  logic              hit;
  logic [DATA_W-1:0] rdata;
  logic              vld;         // valid bit of indexed line
  logic              dirty;
  logic [TAG_W-1:0]  victim_tag;  // stored tag, for write-back addr

  modport ctrl (
    output idx, tag, upd_en, upd_data, upd_strb, upd_dirty, upd_tag,
    input  hit, rdata, vld, dirty, victim_tag
  );

  modport way (
    input  idx, tag, upd_en, upd_data, upd_strb, upd_dirty, upd_tag,
    output hit, rdata, vld, dirty, victim_tag
  );

endinterface

`default_nettype wire

// ==== hw/dcache_way.sv ====
/*
 * one cache way store
 * tag, valid, dirty and data arrays in registers
 * combinational tag compare and strobed line update
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_way #(
  parameter int IDX_W = 6
) (
  input  logic      clk,
  input  logic      rst,
  cache_way_if.way  port
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
  localparam int DEPTH = 1 << IDX_W;

  logic [TAG_W-1:0]  tag_mem  [DEPTH];
  logic [DATA_W-1:0] data_mem [DEPTH];
  logic [DEPTH-1:0]  valid_q;
  logic [DEPTH-1:0]  dirty_q;

  logic [TAG_W-1:0]  cur_tag;
  logic [DATA_W-1:0] cur_data;

  assign cur_tag  = tag_mem[port.idx];
  assign cur_data = data_mem[port.idx];

  // lookup
  assign port.vld        = valid_q[port.idx];
  assign port.dirty      = dirty_q[port.idx];
  assign port.hit        = valid_q[port.idx] && (cur_tag == port.tag);
  assign port.rdata      = cur_data;
  assign port.victim_tag = cur_tag;

  // line state bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (port.upd_en) begin
      valid_q[port.idx] <= 1'b1;
      dirty_q[port.idx] <= port.upd_dirty;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (port.upd_en) begin
      tag_mem[port.idx]  <= port.upd_tag;
      data_mem[port.idx] <= merge_bytes(cur_data, port.upd_data, port.upd_strb);
    end
  end

  // update index comes from the controller's registered request
  a_upd_idx_known: assert property (
    @(posedge clk) disable iff (rst)
    port.upd_en |-> !$isunknown(port.idx)
  ) else $error("dcache_way: update with unknown index");

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
/*
 * data cache controller
 * request FSM, hit selection and victim choice
 * write-back and refill sequencing over the memory channels
 * core read and write responses
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
  parameter int IDX_W = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  cache_way_if.ctrl                     way0,
  cache_way_if.ctrl                     way1,
  // core read
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0] r_data_o,
  // core write
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0] w_data_i,
  input  logic [dcache_pkg::STRB_W-1:0] w_strb_i,
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  // memory side
  output logic                          mem_ar_valid_o,
  input  logic                          mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0] mem_ar_addr_o,
  input  logic                          mem_r_valid_i,
  output logic                          mem_r_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0] mem_r_data_i,
  output logic                          mem_aw_valid_o,
  input  logic                          mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0] mem_aw_addr_o,
  output logic [dcache_pkg::DATA_W-1:0] mem_w_data_o,
  input  logic                          mem_b_valid_i,
  output logic                          mem_b_ready_o
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic [DATA_W-1:0] rdata_q;
  logic              is_wr_q;
  logic              vict_q;
  logic              repl_q;   // free-running replacement bit

  logic              ar_fire;
  logic              aw_fire;
  logic              resp_fire;
  logic              any_hit;
  logic              hit_way;
  logic              vict_d;
  logic              vict_wb;
  logic [IDX_W-1:0]  req_idx;
  logic [TAG_W-1:0]  req_tag;
  logic [DATA_W-1:0] hit_rdata;
  logic [DATA_W-1:0] vic_rdata;
  logic [TAG_W-1:0]  vic_tag;
  logic [DATA_W-1:0] fill_data;
  logic              upd_go;
  logic              upd_way;
  logic [DATA_W-1:0] upd_data;
  logic [STRB_W-1:0] upd_strb;

  // read wins over a write in the same cycle
  assign ar_ready_o = (state_q == S_IDLE);
  assign aw_ready_o = (state_q == S_IDLE) && !ar_valid_i;
  assign ar_fire    = ar_valid_i && ar_ready_o;
  assign aw_fire    = aw_valid_i && aw_ready_o;

  assign req_idx = addr_q[OFF_W +: IDX_W];
  assign req_tag = addr_q[ADDR_W-1 -: TAG_W];

  // hit selection
  assign any_hit   = way0.hit || way1.hit;
  assign hit_way   = way1.hit;
  assign hit_rdata = hit_way ? way1.rdata : way0.rdata;

  // victim prefers an invalid way
  always_comb begin
    if (!way0.vld) begin
      vict_d = 1'b0;
    end else if (!way1.vld) begin
      vict_d = 1'b1;
    end else begin
      vict_d = repl_q;
    end
  end

  assign vict_wb   = vict_d ? (way1.vld && way1.dirty) : (way0.vld && way0.dirty);
  assign vic_rdata = vict_q ? way1.rdata : way0.rdata;
  assign vic_tag   = vict_q ? way1.victim_tag : way0.victim_tag;

  assign resp_fire = is_wr_q ? (b_valid_o && b_ready_i) : (r_valid_o && r_ready_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:      if (ar_fire || aw_fire) state_d = S_LOOKUP;
      S_LOOKUP: begin
        if (any_hit) begin
          state_d = S_RESP;
        end else if (vict_wb) begin
          state_d = S_WB_ADDR;
        end else begin
          state_d = S_FILL_ADDR;
        end
      end
      S_WB_ADDR:   if (mem_aw_ready_i) state_d = S_WB_RESP;
      S_WB_RESP:   if (mem_b_valid_i) state_d = S_FILL_ADDR;
      S_FILL_ADDR: if (mem_ar_ready_i) state_d = S_FILL_DATA;
      S_FILL_DATA: if (mem_r_valid_i) state_d = S_RESP;
      S_RESP:      if (resp_fire) state_d = S_IDLE;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      repl_q  <= 1'b0;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      repl_q  <= ~repl_q;
      if (ar_fire) begin
        is_wr_q <= 1'b0;
      end else if (aw_fire) begin
        is_wr_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q <= ar_addr_i;
    end else if (aw_fire) begin
      addr_q  <= aw_addr_i;
      wdata_q <= w_data_i;
      wstrb_q <= w_strb_i;
    end
    if (state_q == S_LOOKUP) begin
      vict_q  <= vict_d;
      rdata_q <= hit_rdata;
    end
    if (state_q == S_FILL_DATA && mem_r_valid_i) begin
      rdata_q <= mem_r_data_i;
    end
  end

  // way update on write hit or refill
  assign fill_data = merge_bytes(mem_r_data_i, wdata_q, is_wr_q ? wstrb_q : '0);
  assign upd_go    = (state_q == S_LOOKUP && any_hit && is_wr_q) ||
                     (state_q == S_FILL_DATA && mem_r_valid_i);
  assign upd_way   = (state_q == S_LOOKUP) ? hit_way : vict_q;
  assign upd_data  = (state_q == S_LOOKUP) ? wdata_q : fill_data;
  assign upd_strb  = (state_q == S_LOOKUP) ? wstrb_q : '1;

  assign way0.idx       = req_idx;
  assign way0.tag       = req_tag;
  assign way0.upd_en    = upd_go && !upd_way;
  assign way0.upd_data  = upd_data;
  assign way0.upd_strb  = upd_strb;
  assign way0.upd_dirty = is_wr_q;
  assign way0.upd_tag   = req_tag;

  assign way1.idx       = req_idx;
  assign way1.tag       = req_tag;
  assign way1.upd_en    = upd_go && upd_way;
  assign way1.upd_data  = upd_data;
  assign way1.upd_strb  = upd_strb;
  assign way1.upd_dirty = is_wr_q;
  assign way1.upd_tag   = req_tag;

  // core responses
  assign r_valid_o = (state_q == S_RESP) && !is_wr_q;
  assign b_valid_o = (state_q == S_RESP) && is_wr_q;
  assign r_data_o  = rdata_q;

  // memory channels use the full line
  assign mem_aw_valid_o = (state_q == S_WB_ADDR);
  assign mem_aw_addr_o  = {vic_tag, req_idx, {OFF_W{1'b0}}};
  assign mem_w_data_o   = vic_rdata;
  assign mem_b_ready_o  = (state_q == S_WB_RESP);
  assign mem_ar_valid_o = (state_q == S_FILL_ADDR);
  assign mem_ar_addr_o  = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == S_FILL_DATA);

  a_one_hit: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == S_LOOKUP) |-> !(way0.hit && way1.hit)
  ) else $error("dcache_ctrl: both ways hit");

  a_r_stable: assert property (
    @(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o)
  ) else $error("dcache_ctrl: read response changed under stall");

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
/*
 * 2-way set-associative write-back data cache
 * two way stores and the controller behind plain valid/ready ports
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
  parameter int IDX_W = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  // core read
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0] r_data_o,
  // core write
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0] w_data_i,
  input  logic [dcache_pkg::STRB_W-1:0] w_strb_i,
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  // main memory
  output logic                          mem_ar_valid_o,
  input  logic                          mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0] mem_ar_addr_o,
  input  logic                          mem_r_valid_i,
  output logic                          mem_r_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0] mem_r_data_i,
  output logic                          mem_aw_valid_o,
  input  logic                          mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0] mem_aw_addr_o,
  output logic [dcache_pkg::DATA_W-1:0] mem_w_data_o,
  input  logic                          mem_b_valid_i,
  output logic                          mem_b_ready_o
);

  cache_way_if #(.IDX_W(IDX_W)) way0_if ();
  cache_way_if #(.IDX_W(IDX_W)) way1_if ();

  dcache_way #(.IDX_W(IDX_W)) u_way0 (
    .clk  (clk),
    .rst  (rst),
    .port (way0_if.way)
  );

  dcache_way #(.IDX_W(IDX_W)) u_way1 (
    .clk  (clk),
    .rst  (rst),
    .port (way1_if.way)
  );

  dcache_ctrl #(.IDX_W(IDX_W)) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .way0           (way0_if.ctrl),
    .way1           (way1_if.ctrl),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_data_o       (r_data_o),
    .aw_valid_i     (aw_valid_i),
    .aw_ready_o     (aw_ready_o),
    .aw_addr_i      (aw_addr_i),
    .w_data_i       (w_data_i),
    .w_strb_i       (w_strb_i),
    .b_valid_o      (b_valid_o),
    .b_ready_i      (b_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_data_o   (mem_w_data_o),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
/*
 * main memory responder for the cache testbench
 * sparse backing store with an address based fill pattern
 * random ready and valid delays, write-backs kept in the store
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
  parameter int SEED = 1
) (
  input  logic                          clk,
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0] r_data_o,
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0] w_data_i,
  output logic                          b_valid_o,
  input  logic                          b_ready_i
);
  import dcache_pkg::*;

  logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];
  int                seed;

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {addr ^ 32'h9e37_79b9, ~addr + 32'h0bad_f00d};
  endfunction

  task automatic random_wait();
    repeat ($unsigned($random(seed)) % 4) @(negedge clk);
  endtask

  // one transfer at a time, the cache blocks
  initial begin
    logic [ADDR_W-1:0] addr;
    seed       = SEED;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    aw_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    forever begin
      @(negedge clk);
      if (aw_valid_i === 1'b1) begin
        random_wait();
        aw_ready_o = 1'b1;
        store[aw_addr_i] = w_data_i;  // full line
        @(negedge clk);
        aw_ready_o = 1'b0;
        random_wait();
        b_valid_o = 1'b1;
        while (b_ready_i !== 1'b1) @(negedge clk);
        @(negedge clk);
        b_valid_o = 1'b0;
      end else if (ar_valid_i === 1'b1) begin
        random_wait();
        ar_ready_o = 1'b1;
        addr = ar_addr_i;
        @(negedge clk);
        ar_ready_o = 1'b0;
        random_wait();
        r_valid_o = 1'b1;
        r_data_o  = store.exists(addr) ? store[addr] : fill_word(addr);
        while (r_ready_i !== 1'b1) @(negedge clk);
        @(negedge clk);
        r_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache.sv ====
/*
 * data cache testbench
 * random loads and stores checked against a golden memory model
 * hit latency, response stall, write-back and readback checks
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
  import dcache_pkg::*;

  localparam int IDX_W = 6;
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
  localparam int N_TXN = 600;
  localparam int LIMIT = 400 * (N_TXN + 12);  // 12 readbacks at most

  logic              clk;
  logic              rst;
  logic              ar_valid_i;
  logic              ar_ready_o;
  logic [ADDR_W-1:0] ar_addr_i;
  logic              r_valid_o;
  logic              r_ready_i;
  logic [DATA_W-1:0] r_data_o;
  logic              aw_valid_i;
  logic              aw_ready_o;
  logic [ADDR_W-1:0] aw_addr_i;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              b_valid_o;
  logic              b_ready_i;
  logic              mem_ar_valid_o;
  logic              mem_ar_ready_i;
  logic [ADDR_W-1:0] mem_ar_addr_o;
  logic              mem_r_valid_i;
  logic              mem_r_ready_o;
  logic [DATA_W-1:0] mem_r_data_i;
  logic              mem_aw_valid_o;
  logic              mem_aw_ready_i;
  logic [ADDR_W-1:0] mem_aw_addr_o;
  logic [DATA_W-1:0] mem_w_data_o;
  logic              mem_b_valid_i;
  logic              mem_b_ready_o;

  int                seed;
  int                cycles = 0;
  int                wb_cnt = 0;
  logic [ADDR_W-1:0] last_addr;
  logic [DATA_W-1:0] gold [logic [ADDR_W-1:0]];
  logic              touched [logic [ADDR_W-1:0]];

  dcache_top #(.IDX_W(IDX_W)) dut0 (.*);

  tb_mem_model #(.SEED(32'hdc80_94d6)) u_mem (
    .clk        (clk),
    .ar_valid_i (mem_ar_valid_o),
    .ar_ready_o (mem_ar_ready_i),
    .ar_addr_i  (mem_ar_addr_o),
    .r_valid_o  (mem_r_valid_i),
    .r_ready_i  (mem_r_ready_o),
    .r_data_o   (mem_r_data_i),
    .aw_valid_i (mem_aw_valid_o),
    .aw_ready_o (mem_aw_ready_i),
    .aw_addr_i  (mem_aw_addr_o),
    .w_data_i   (mem_w_data_o),
    .b_valid_o  (mem_b_valid_i),
    .b_ready_i  (mem_b_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // same fill pattern as the memory model
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {addr ^ 32'h9e37_79b9, ~addr + 32'h0bad_f00d};
  endfunction

  function automatic logic [DATA_W-1:0] gold_value(input logic [ADDR_W-1:0] addr);
    return gold.exists(addr) ? gold[addr] : fill_word(addr);
  endfunction

  // strobed byte lanes take the new data
  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_data,
                                                      input logic [DATA_W-1:0] new_data,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < STRB_W; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_data & ~mask) | (new_data & mask);
  endfunction

  // 3 tags over 4 sets
  function automatic logic [ADDR_W-1:0] pick_addr(input int t, input int s);
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    tag = TAG_W'(t * 32'h1_3579 + 32'h42);
    idx = IDX_W'(s * 13 + 5);
    return {tag, idx, {OFF_W{1'b0}}};
  endfunction

  task automatic fail_now();
    $display("Simulation failed");
    $fatal(1);
  endtask

  // one load or store from request to response transfer
  task automatic access(input logic wr, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                        input logic expect_hit);
    int                lat;
    int                stall;
    logic [DATA_W-1:0] exp;
    exp = gold_value(addr);
    touched[addr] = 1'b1;
    ar_valid_i = !wr;
    aw_valid_i = wr;
    ar_addr_i  = addr;
    aw_addr_i  = addr;
    w_data_i   = data;
    w_strb_i   = strb;
    while (!(wr ? aw_ready_o : ar_ready_o)) @(negedge clk);
    @(negedge clk);  // request taken on the edge just passed
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    if (wr) gold[addr] = apply_strobes(exp, data, strb);
    lat = 0;
    while (!(r_valid_o || b_valid_o)) begin
      @(negedge clk);
      lat++;
    end
    assert (r_valid_o === !wr && b_valid_o === wr) else begin
      $display("response came on the wrong channel for address %h", addr);
      fail_now();
    end
    if (expect_hit) begin
      assert (lat == 1) else begin
        $display("error: r_valid_o latency got %0h expected %0h", lat, 1);
        fail_now();
      end
    end
    assert (wr || r_data_o === exp) else begin
      $display("error: r_data_o at %h got %h expected %h", addr, r_data_o, exp);
      fail_now();
    end
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) begin
      @(negedge clk);
      assert (r_valid_o === !wr && b_valid_o === wr) else begin
        $display("response dropped while stalled at address %h", addr);
        fail_now();
      end
      assert (wr || r_data_o === exp) else begin
        $display("error: r_data_o under stall at %h got %h expected %h", addr, r_data_o, exp);
        fail_now();
      end
    end
    r_ready_i = !wr;
    b_ready_i = wr;
    @(negedge clk);
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    assert (!r_valid_o && !b_valid_o && ar_ready_o) else begin
      $display("second response or no return to idle after address %h", addr);
      fail_now();
    end
    last_addr = addr;
  endtask

  // write-backs and timeout
  always @(posedge clk) begin
    cycles++;
    if (mem_aw_valid_o === 1'b1 && mem_aw_ready_i === 1'b1) begin
      wb_cnt++;
      assert (mem_w_data_o === gold_value(mem_aw_addr_o)) else begin
        $display("error: mem_w_data_o at %h got %h expected %h", mem_aw_addr_o,
                 mem_w_data_o, gold_value(mem_aw_addr_o));
        fail_now();
      end
    end
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      fail_now();
    end
  end

  initial begin
    int                op;
    logic [ADDR_W-1:0] addr;
    seed       = 32'hdc80_94d6;
    rst        = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (ar_ready_o === 1'b1 && aw_ready_o === 1'b1 && r_valid_o === 1'b0 &&
            b_valid_o === 1'b0 && mem_ar_valid_o === 1'b0 && mem_aw_valid_o === 1'b0 &&
            mem_r_ready_o === 1'b0 && mem_b_ready_o === 1'b0) else begin
      $display("outputs not idle after reset");
      fail_now();
    end
    for (int t = 0; t < N_TXN; t++) begin
      op = $unsigned($random(seed)) % 4;
      repeat ($unsigned($random(seed)) % 3) @(negedge clk);
      if (op == 3 && t > 0) begin
        access(1'b0, last_addr, '0, '0, 1'b1);  // must hit
      end else begin
        addr = pick_addr($unsigned($random(seed)) % 3, $unsigned($random(seed)) % 4);
        access(op != 0, addr, {$random(seed), $random(seed)}, $random(seed), 1'b0);
      end
    end
    // read back everything touched
    if (touched.first(addr)) begin
      do begin
        access(1'b0, addr, '0, '0, 1'b0);
      end while (touched.next(addr));
    end
    if (wb_cnt > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("no write-back was exercised");
      fail_now();
    end
  end

endmodule

`default_nettype wire

// ==== dcache_sys.f ====
hw/dcache_pkg.sv
hw/cache_way_if.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache_sys

sources:
  - hw/dcache_pkg.sv
  - hw/cache_way_if.sv
  - hw/dcache_way.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_dcache.sv
